/* div_chk.sv */
module div_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     src_valid,
    input logic                     src_ready,
    input logic                     dest_valid,
    input logic                     dest_ready,
    input div_ctrl_pkg::dp_ctrl_t   ctrl,
    input div_types_pkg::div_resp_t resp
);

    // accept edge plus one edge per quotient bit
    localparam int RESULT_LATENCY = div_types_pkg::DIV_STEPS + 1;

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst)
        !(ctrl.load && ctrl.step)
    ) else $error("load and step strobes high in the same cycle");

    ports_exclusive: assert property (
        @(posedge clk) disable iff (!rst)
        !(src_ready && dest_valid)
    ) else $error("src_ready and dest_valid high in the same cycle");

    resp_held: assert property (
        @(posedge clk) disable iff (!rst)
        (dest_valid && !dest_ready) |=> $stable(resp)
    ) else $error("resp changed while the result was held back");

    result_latency: assert property (
        @(posedge clk) disable iff (!rst)
        (src_valid && src_ready) |-> ##RESULT_LATENCY $rose(dest_valid)
    ) else $error("dest_valid did not rise at the expected cycle after acceptance");

endmodule

bind restoring_divider div_chk chk_i (
    .clk        (clk),
    .rst        (rst),
    .src_valid  (src_valid),
    .src_ready  (src_ready),
    .dest_valid (dest_valid),
    .dest_ready (dest_ready),
    .ctrl       (ctrl),
    .resp       (resp)
);

/* div_ctrl.sv */
module div_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   src_valid,
    input  logic                   dest_ready,
    output logic                   src_ready,
    output logic                   dest_valid,
    output div_ctrl_pkg::dp_ctrl_t ctrl
);

    div_ctrl_pkg::div_state_t   current_state;
    div_ctrl_pkg::div_state_t   next_state;
    div_types_pkg::step_count_t step_count;
    logic                       last_step;

    // final iteration of the current division
    assign last_step = (step_count ==
                        div_types_pkg::step_count_t'(div_types_pkg::DIV_STEPS - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            current_state <= div_ctrl_pkg::IDLE;
        end else begin
            current_state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            step_count <= '0;
        end else if (ctrl.load) begin
            step_count <= '0; // fresh division
        end else if (ctrl.step) begin
            step_count <= step_count + div_types_pkg::step_count_t'(1);
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            div_ctrl_pkg::IDLE: begin
                if (src_valid) begin
                    next_state = div_ctrl_pkg::BUSY;
                end
            end
            div_ctrl_pkg::BUSY: begin
                if (last_step) begin
                    next_state = div_ctrl_pkg::DONE;
                end
            end
            div_ctrl_pkg::DONE: begin
                if (dest_ready) begin
                    next_state = div_ctrl_pkg::IDLE; // result taken
                end
            end
            default: begin
                next_state = div_ctrl_pkg::IDLE;
            end
        endcase
    end

    // outputs depend on state and handshake inputs only
    always_comb begin
        src_ready  = 1'b0;
        dest_valid = 1'b0;
        ctrl       = '0;
        case (current_state)
            div_ctrl_pkg::IDLE: begin
                src_ready = 1'b1;
                ctrl.load = src_valid; // capture on the accepting edge
            end
            div_ctrl_pkg::BUSY: begin
                ctrl.step = 1'b1;
            end
            div_ctrl_pkg::DONE: begin
                dest_valid = 1'b1; // held through back-pressure
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* div_ctrl_pkg.sv */
package div_ctrl_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE = 2'b00, // waiting for a request
        BUSY = 2'b01, // iterating
        DONE = 2'b10  // result held for the consumer
    } div_state_t;

    // datapath strobes, never both high
    typedef struct packed {
        logic load; // capture operands
        logic step; // one restoring iteration
    } dp_ctrl_t;

endpackage

/* div_types_pkg.sv */
package div_types_pkg;

    // number of quotient bits, one per iteration
    parameter int DIV_STEPS = 32;

    // dividend, divisor, quotient, remainder
    typedef logic [31:0] operand_t;

    // partial remainder with guard bit for the sign of the trial
    typedef logic [32:0] partial_t;

    // counts 0 .. DIV_STEPS-1
    typedef logic [5:0] step_count_t;

    typedef struct packed {
        operand_t dividend;
        operand_t divisor;
    } div_req_t;

    typedef struct packed {
        operand_t quotient;
        operand_t remainder;
    } div_resp_t;

endpackage

/* filelist.f */
div_types_pkg.sv
div_ctrl_pkg.sv
div_ctrl.sv
remainder_unit.sv
quotient_shifter.sv
restoring_divider.sv
div_chk.sv
tb_restoring_divider.sv

/* quotient_shifter.sv */
module quotient_shifter (
    input  logic                    clk,
    input  logic                    rst,
    input  div_ctrl_pkg::dp_ctrl_t  ctrl,
    input  div_types_pkg::operand_t dividend,
    input  logic                    q_bit,
    output logic                    dividend_msb,
    output div_types_pkg::operand_t quotient
);

    localparam int OP_W = $bits(div_types_pkg::operand_t);

    // dividend bits leave at the top, quotient bits enter at the bottom
    div_types_pkg::operand_t shift_reg;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            shift_reg <= '0;
        end else if (ctrl.load) begin
            shift_reg <= dividend;
        end else if (ctrl.step) begin
            shift_reg <= {shift_reg[OP_W-2:0], q_bit};
        end
    end

    assign dividend_msb = shift_reg[OP_W-1];
    assign quotient     = shift_reg; // valid once all steps are done

endmodule

/* remainder_unit.sv */
module remainder_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  div_ctrl_pkg::dp_ctrl_t  ctrl,
    input  div_types_pkg::operand_t divisor,
    input  logic                    dividend_msb,
    output logic                    q_bit,
    output div_types_pkg::operand_t remainder
);

    localparam int OP_W = $bits(div_types_pkg::operand_t);

    div_types_pkg::operand_t divisor_reg;
    div_types_pkg::partial_t partial_reg;
    div_types_pkg::partial_t shifted;
    div_types_pkg::partial_t trial;

    // next dividend bit enters at the bottom
    assign shifted = {partial_reg[OP_W-1:0], dividend_msb};

    // zero-extended divisor, guard bit gives the sign
    assign trial = shifted - div_types_pkg::partial_t'(divisor_reg);

    // 1 when the trial did not go negative
    assign q_bit = ~trial[OP_W];

    assign remainder = partial_reg[OP_W-1:0];

    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            divisor_reg <= divisor;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            partial_reg <= '0;
        end else if (ctrl.load) begin
            partial_reg <= '0;
        end else if (ctrl.step) begin
            if (q_bit) begin
                partial_reg <= trial;
            end else begin
                partial_reg <= shifted; // restore
            end
        end
    end

endmodule

/* restoring_divider.sv */
module restoring_divider (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     src_valid,
    output logic                     src_ready,
    input  div_types_pkg::div_req_t  req,
    output logic                     dest_valid,
    input  logic                     dest_ready,
    output div_types_pkg::div_resp_t resp
);

    div_ctrl_pkg::dp_ctrl_t  ctrl;
    logic                    dividend_msb;
    logic                    q_bit;
    div_types_pkg::operand_t quotient;
    div_types_pkg::operand_t remainder;

    div_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .dest_ready (dest_ready),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .ctrl       (ctrl)
    );

    remainder_unit rem_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .divisor      (req.divisor),
        .dividend_msb (dividend_msb),
        .q_bit        (q_bit),
        .remainder    (remainder)
    );

    quotient_shifter quo_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .dividend     (req.dividend),
        .q_bit        (q_bit),
        .dividend_msb (dividend_msb),
        .quotient     (quotient)
    );

    // registers hold the result stable while in DONE
    assign resp.quotient  = quotient;
    assign resp.remainder = remainder;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the divider testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        -f filelist.f \
        --top-module tb_restoring_divider; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_restoring_divider 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** PASSED ***' <<< "$sim_output"; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi

/* tb_restoring_divider.sv */
module tb_restoring_divider;

    localparam int RESULT_LATENCY = div_types_pkg::DIV_STEPS + 1;
    localparam int RAND_DIVS      = 200;
    localparam int DIRECTED_DIVS  = 14;
    localparam int NUM_DIVS       = RAND_DIVS + DIRECTED_DIVS;
    localparam int TIMEOUT_CYCLES = NUM_DIVS * 40 + 300; // margin covers back-pressure holds

    logic                     clk;
    logic                     rst;
    logic                     src_valid;
    logic                     src_ready;
    div_types_pkg::div_req_t  req;
    logic                     dest_valid;
    logic                     dest_ready;
    div_types_pkg::div_resp_t resp;

    logic [31:0] lfsr_state = 32'h52b3e2ab;
    int          cycle_count = 0;

    restoring_divider dut_i (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .req        (req),
        .dest_valid (dest_valid),
        .dest_ready (dest_ready),
        .resp       (resp)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout, the divider did not finish within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            bits       = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    function automatic div_types_pkg::div_resp_t expected_resp(
        input div_types_pkg::operand_t dividend,
        input div_types_pkg::operand_t divisor
    );
        div_types_pkg::div_resp_t r;
        if (divisor == '0) begin
            r.quotient  = '1; // restoring algorithm with zero divisor
            r.remainder = dividend;
        end else begin
            r.quotient  = dividend / divisor;
            r.remainder = dividend % divisor;
        end
        return r;
    endfunction

    task automatic check_resp(input div_types_pkg::div_resp_t expected);
        assert (resp.quotient == expected.quotient) else
            report_failure($sformatf("FAILED quotient: got %h expected %h",
                                     resp.quotient, expected.quotient));
        assert (resp.remainder == expected.remainder) else
            report_failure($sformatf("FAILED remainder: got %h expected %h",
                                     resp.remainder, expected.remainder));
    endtask

    task automatic check_idle();
        assert (src_ready == 1'b1) else
            report_failure($sformatf("FAILED src_ready: got %h expected %h", src_ready, 1'b1));
        assert (dest_valid == 1'b0) else
            report_failure($sformatf("FAILED dest_valid: got %h expected %h", dest_valid, 1'b0));
    endtask

    // one request, result checked, optional hold of dest_ready low
    task automatic divide(
        input div_types_pkg::operand_t dividend,
        input div_types_pkg::operand_t divisor,
        input int                      hold_cycles,
        input bit                      ready_early
    );
        div_types_pkg::div_resp_t expected;
        int                       latency;
        expected      = expected_resp(dividend, divisor);
        req.dividend  = dividend;
        req.divisor   = divisor;
        src_valid     = 1'b1;
        dest_ready    = ready_early;
        while (!src_ready) begin
            @(negedge clk);
        end
        @(negedge clk); // accepted on the edge just passed
        src_valid = 1'b0;
        latency   = 1;
        while (!dest_valid) begin
            @(negedge clk);
            latency++;
        end
        assert (latency == RESULT_LATENCY) else
            report_failure($sformatf("FAILED dest_valid latency: got %h expected %h",
                                     latency, RESULT_LATENCY));
        check_resp(expected);
        if (!ready_early) begin
            for (int i = 0; i < hold_cycles; i++) begin
                @(negedge clk);
                assert (dest_valid) else
                    report_failure("dest_valid dropped before the result was taken");
                assert (resp == expected) else
                    report_failure($sformatf("FAILED resp: got %h expected %h", resp, expected));
            end
            dest_ready = 1'b1;
        end
        @(negedge clk); // result taken
        if (!ready_early) begin
            dest_ready = 1'b0;
        end
        check_idle();
    endtask

    task automatic fixed_cases();
        divide(32'd100, 32'd7, 0, 1'b0);
        divide(32'd5, 32'd9, 0, 1'b0);
        divide(32'd1234, 32'd1234, 0, 1'b0);
        divide(32'hdeadbeef, 32'd1, 0, 1'b0);
        divide(32'hffffffff, 32'd3, 0, 1'b0);
        divide(32'hffffffff, 32'hffffffff, 0, 1'b0);
    endtask

    task automatic zero_divisor();
        divide(32'd12345, 32'd0, 0, 1'b0);
        divide(32'hffffffff, 32'd0, 0, 1'b0);
        divide(32'd0, 32'd0, 0, 1'b0);
    endtask

    task automatic back_pressure();
        int hold;
        for (int n = 0; n < 3; n++) begin
            hold = int'(take_bits(4)) + 1;
            divide(take_bits(32), take_bits(16), hold, 1'b0);
        end
    endtask

    // a second request held during BUSY must not disturb the running division
    task automatic busy_request_ignored();
        div_types_pkg::div_resp_t expected;
        expected     = expected_resp(32'd1000000, 32'd999);
        req.dividend = 32'd1000000;
        req.divisor  = 32'd999;
        src_valid    = 1'b1;
        dest_ready   = 1'b0;
        while (!src_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req.dividend = 32'hcafef00d;
        req.divisor  = 32'd17;
        while (!dest_valid) begin
            assert (!src_ready) else
                report_failure("src_ready went high while a division was running");
            @(negedge clk);
        end
        check_resp(expected);
        src_valid  = 1'b0;
        dest_ready = 1'b1;
        @(negedge clk);
        dest_ready = 1'b0;
        check_idle();
        divide(32'h0badf00d, 32'd251, 0, 1'b0);
    endtask

    task automatic random_back_to_back();
        div_types_pkg::operand_t dividend;
        div_types_pkg::operand_t divisor;
        for (int n = 0; n < RAND_DIVS; n++) begin
            dividend = take_bits(32);
            divisor  = take_bits(32);
            if (n % 4 == 3) begin
                divisor = divisor & 32'h0000_00ff; // small divisors, long quotients
            end else if (n % 8 == 5) begin
                dividend = dividend & 32'h0000_ffff;
            end
            divide(dividend, divisor, 0, 1'b1);
        end
        dest_ready = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        src_valid  = 1'b0;
        dest_ready = 1'b0;
        req        = '0;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        check_idle();
        fixed_cases();
        zero_divisor();
        back_pressure();
        busy_request_ignored();
        random_back_to_back();
        @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule
